/* hw/capture_pkg.sv */
/*
 * capture package
 * widths, types and constants shared by the sample capture path
 */
`default_nettype none

package capture_pkg;

   // sample and packet framing
   localparam int SAMPLE_W = 16;
   localparam int PKT_LEN  = 8;

   // default FIFO depth is 2^FIFO_AW words
   localparam int FIFO_AW  = 9;

   typedef logic [SAMPLE_W-1:0] sample_t;
   typedef logic [2:0]          beat_cnt_t;

   // fill levels and the drop count
   typedef logic [15:0] level_t;

   // packet sum, wraps modulo 2^16
   typedef logic [15:0] sum_t;

   // FIFO read side
   typedef enum logic [1:0] {
      EMPTY,
      PRE_READ,
      READING
   } read_state_t;

endpackage

`default_nettype wire

/* hw/sample_stream_if.sv */
/*
 * sample stream interface
 * valid/ready stream of samples with a last flag per packet
 */
`default_nettype none

interface sample_stream_if
   import capture_pkg::*;
();

   sample_t tdata;
   logic    tlast;
   logic    tvalid;
   logic    tready;

   modport source (output tdata, output tlast, output tvalid, input tready);
   modport sink   (input tdata, input tlast, input tvalid, output tready);

endinterface

`default_nettype wire

/* hw/ram_2port.sv */
/*
 * dual-port block RAM
 * one write port, one read port with a registered read enable
 */
`default_nettype none

module ram_2port
   import capture_pkg::*;
#(
   parameter int WIDTH = SAMPLE_W + 1,
   parameter int SIZE  = FIFO_AW
)
(
   input  wire              clk,
   input  wire              i_wr_en,
   input  wire  [SIZE-1:0]  i_wr_addr,
   input  wire  [WIDTH-1:0] i_wr_data,
   input  wire              i_rd_en,
   input  wire  [SIZE-1:0]  i_rd_addr,
   output logic [WIDTH-1:0] o_rd_data
);

   logic [WIDTH-1:0] mem [0:(1<<SIZE)-1];

   // port A write
   always_ff @(posedge clk)
   begin
      if (i_wr_en)
         mem[i_wr_addr] <= i_wr_data;
   end

   // port B read, output holds while disabled
   always_ff @(posedge clk)
   begin
      if (i_rd_en)
         o_rd_data <= mem[i_rd_addr];
   end

endmodule

`default_nettype wire

/* hw/sample_packetizer.sv */
/*
 * sample packetizer
 * frames sample strobes into fixed-length packets on a stream
 * and counts samples that arrive while the holding word is busy
 */
`default_nettype none

module sample_packetizer
   import capture_pkg::*;
(
   input  wire             clk,
   input  wire             reset,
   input  wire             i_clear,
   input  wire sample_t    i_sample,
   input  wire             i_sample_strobe,
   output level_t          o_dropped,
   sample_stream_if.source o_stream
);

   beat_cnt_t beat;
   sample_t   hold_data;
   logic      hold_last;
   logic      hold_valid;
   logic      accept;
   logic      last_beat;

   // free holding stage, or the pending word leaves this cycle
   assign accept    = i_sample_strobe & (~hold_valid | o_stream.tready);
   assign last_beat = (beat == beat_cnt_t'(PKT_LEN - 1));

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         hold_valid <= 1'b0;
         beat       <= '0;
      end
      else if (accept)
      begin
         hold_valid <= 1'b1;
         beat       <= last_beat ? '0 : beat + beat_cnt_t'(1);
      end
      else if (o_stream.tready)
         hold_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         hold_data <= i_sample;
         hold_last <= last_beat;
      end
   end

   // saturating drop count
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         o_dropped <= '0;
      else if (i_sample_strobe && !accept && o_dropped != '1)
         o_dropped <= o_dropped + level_t'(1);
   end

   assign o_stream.tdata  = hold_data;
   assign o_stream.tlast  = hold_last;
   assign o_stream.tvalid = hold_valid;

endmodule

`default_nettype wire

/* hw/axi_fifo_bram.sv */
/*
 * block RAM stream FIFO
 * pre-reads the RAM so the head word is ready, drives a registered
 * output stage and keeps space and occupied counters
 */
`default_nettype none

module axi_fifo_bram
   import capture_pkg::*;
#(
   parameter int WIDTH = SAMPLE_W + 1,
   parameter int SIZE  = FIFO_AW
)
(
   input  wire             clk,
   input  wire             reset,
   input  wire             i_clear,
   sample_stream_if.sink   i_stream,
   sample_stream_if.source o_stream,
   output level_t          o_space,
   output level_t          o_occupied
);

   logic             write;
   logic             read;
   logic             full;
   logic             empty;
   logic             int_tready;
   logic [WIDTH-1:0] int_tdata;
   logic [WIDTH-1:0] out_data;
   logic             out_valid;
   logic [SIZE-1:0]  wr_addr;
   logic [SIZE-1:0]  rd_addr;
   logic [SIZE-1:0]  dont_write_past_me;
   logic             becoming_full;
   read_state_t      read_state;

   assign i_stream.tready = ~full;
   assign write           = i_stream.tvalid & i_stream.tready;
   assign read            = ~empty & int_tready;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         wr_addr <= '0;
      else if (write)
         wr_addr <= wr_addr + SIZE'(1);
   end

   // sample in the low bits, last flag on top
   ram_2port #(
      .WIDTH (WIDTH),
      .SIZE  (SIZE)
   ) ram_inst (
      .clk       (clk),
      .i_wr_en   (write),
      .i_wr_addr (wr_addr),
      .i_wr_data ({i_stream.tlast, i_stream.tdata}),
      .i_rd_en   ((read_state == PRE_READ) | read),
      .i_rd_addr (rd_addr),
      .o_rd_data (int_tdata)
   );

   // read side, PRE_READ fetches the head word before it is needed
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         read_state <= EMPTY;
         rd_addr    <= '0;
         empty      <= 1'b1;
      end
      else
      begin
         case (read_state)
            EMPTY:
            begin
               if (write)
                  read_state <= PRE_READ;
            end
            PRE_READ:
            begin
               read_state <= READING;
               empty      <= 1'b0;
               rd_addr    <= rd_addr + SIZE'(1);
            end
            READING:
            begin
               if (read)
               begin
                  if (rd_addr == wr_addr)
                  begin
                     // last stored word just left
                     empty      <= 1'b1;
                     read_state <= write ? PRE_READ : EMPTY;
                  end
                  else
                     rd_addr <= rd_addr + SIZE'(1);
               end
            end
            default:
               read_state <= EMPTY;
         endcase
      end
   end

   // full two addresses short of the read pointer
   assign dont_write_past_me = rd_addr - SIZE'(2);
   assign becoming_full      = (wr_addr == dont_write_past_me);

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         full <= 1'b0;
      else if (read && !write)
         full <= 1'b0;
      else if (write && !read && becoming_full)
         full <= 1'b1;
   end

   // output register, loads when empty or being drained
   assign int_tready = o_stream.tready | ~out_valid;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
         out_valid <= 1'b0;
      else if (int_tready)
         out_valid <= ~empty;
   end

   always_ff @(posedge clk)
   begin
      if (int_tready)
         out_data <= int_tdata;
   end

   assign o_stream.tvalid                 = out_valid;
   assign {o_stream.tlast, o_stream.tdata} = out_data;

   // fill counters, only unmatched reads and writes move them
   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         o_space    <= level_t'(1 << SIZE);
         o_occupied <= '0;
      end
      else if (read && !write)
      begin
         o_space    <= o_space + level_t'(1);
         o_occupied <= o_occupied - level_t'(1);
      end
      else if (write && !read)
      begin
         o_space    <= o_space - level_t'(1);
         o_occupied <= o_occupied + level_t'(1);
      end
   end

endmodule

`default_nettype wire

/* hw/packet_checksum.sv */
/*
 * packet checksum
 * passes the stream to the output port and sums each packet
 */
`default_nettype none

module packet_checksum
   import capture_pkg::*;
(
   input  wire           clk,
   input  wire           reset,
   input  wire           i_clear,
   sample_stream_if.sink i_stream,
   output sample_t       o_data,
   output logic          o_last,
   output logic          o_valid,
   input  wire           i_ready,
   output sum_t          o_sum,
   output logic          o_sum_valid
);

   sum_t acc;
   logic xfer;

   // stream goes straight through
   assign o_data          = i_stream.tdata;
   assign o_last          = i_stream.tlast;
   assign o_valid         = i_stream.tvalid;
   assign i_stream.tready = i_ready;

   assign xfer = i_stream.tvalid & i_ready;

   always_ff @(posedge clk)
   begin
      if (reset || i_clear)
      begin
         acc         <= '0;
         o_sum_valid <= 1'b0;
      end
      else
      begin
         o_sum_valid <= xfer & i_stream.tlast;
         if (xfer)
            acc <= i_stream.tlast ? '0 : acc + sum_t'(i_stream.tdata);
      end
   end

   // completed sum includes the last word
   always_ff @(posedge clk)
   begin
      if (xfer && i_stream.tlast)
         o_sum <= acc + sum_t'(i_stream.tdata);
   end

endmodule

`default_nettype wire

/* hw/capture_top.sv */
/*
 * sample capture top
 * packetizer into block RAM FIFO into checksum, plain ports outside
 */
`default_nettype none

module capture_top
   import capture_pkg::*;
(
   input  wire          clk,
   input  wire          reset,
   input  wire          i_clear,
   input  wire sample_t i_sample,
   input  wire          i_sample_strobe,
   input  wire          i_ready,
   output sample_t      o_data,
   output logic         o_last,
   output logic         o_valid,
   output sum_t         o_sum,
   output logic         o_sum_valid,
   output level_t       o_dropped,
   output level_t       o_space,
   output level_t       o_occupied
);

   sample_stream_if pk2fifo ();
   sample_stream_if fifo2ck ();

   sample_packetizer sample_packetizer_inst (
      .clk             (clk),
      .reset           (reset),
      .i_clear         (i_clear),
      .i_sample        (i_sample),
      .i_sample_strobe (i_sample_strobe),
      .o_dropped       (o_dropped),
      .o_stream        (pk2fifo.source)
   );

   // sample plus last flag per entry
   axi_fifo_bram #(
      .WIDTH (SAMPLE_W + 1),
      .SIZE  (FIFO_AW)
   ) axi_fifo_bram_inst (
      .clk        (clk),
      .reset      (reset),
      .i_clear    (i_clear),
      .i_stream   (pk2fifo.sink),
      .o_stream   (fifo2ck.source),
      .o_space    (o_space),
      .o_occupied (o_occupied)
   );

   packet_checksum packet_checksum_inst (
      .clk         (clk),
      .reset       (reset),
      .i_clear     (i_clear),
      .i_stream    (fifo2ck.sink),
      .o_data      (o_data),
      .o_last      (o_last),
      .o_valid     (o_valid),
      .i_ready     (i_ready),
      .o_sum       (o_sum),
      .o_sum_valid (o_sum_valid)
   );

endmodule

`default_nettype wire

/* sim/capture_assert.sv */
/*
 * FIFO assertions
 * bound into axi_fifo_bram, check the full flag, output stalls,
 * the fill counters and the idle output after reset or clear
 */
`default_nettype none

module capture_assert
   import capture_pkg::*;
#(
   parameter int WIDTH = SAMPLE_W + 1,
   parameter int SIZE  = FIFO_AW
)
(
   input wire             clk,
   input wire             reset,
   input wire             i_clear,
   input wire             i_write,
   input wire             i_full,
   input wire             i_out_valid,
   input wire             i_out_ready,
   input wire [WIDTH-1:0] i_out_data,
   input wire level_t     i_space,
   input wire level_t     i_occupied
);

   timeunit 1ns;
   timeprecision 100ps;

   int fail_count = 0;

   // a write needs room by the fill counters
   no_write_when_full: assert property (@(posedge clk) disable iff (reset)
      i_write |-> (i_space != '0))
   else
   begin
      $error("write accepted while the FIFO is full");
      fail_count++;
   end

   // stalled output keeps its word
   stall_holds_output: assert property (@(posedge clk) disable iff (reset || i_clear)
      (i_out_valid && !i_out_ready) |=> (i_out_valid && $stable(i_out_data)))
   else
   begin
      $error("output word changed while stalled");
      fail_count++;
   end

   // full flag set exactly when no space is left
   counters_add_up: assert property (@(posedge clk) disable iff (reset)
      ((32'(i_space) + 32'(i_occupied)) == (1 << SIZE)) && (i_full == (i_space == '0)))
   else
   begin
      $error("fill counters do not add up to the depth or disagree with the full flag");
      fail_count++;
   end

   idle_after_clear: assert property (@(posedge clk)
      (reset || i_clear) |=> !i_out_valid)
   else
   begin
      $error("output valid right after reset or clear");
      fail_count++;
   end

endmodule

bind axi_fifo_bram capture_assert #(
   .WIDTH (WIDTH),
   .SIZE  (SIZE)
) capture_assert_inst (
   .clk         (clk),
   .reset       (reset),
   .i_clear     (i_clear),
   .i_write     (write),
   .i_full      (full),
   .i_out_valid (out_valid),
   .i_out_ready (o_stream.tready),
   .i_out_data  (out_data),
   .i_space     (o_space),
   .i_occupied  (o_occupied)
);

`default_nettype wire

/* sim/capture_tb.sv */
/*
 * capture testbench
 * sparse, back-pressured and cleared traffic through capture_top,
 * checked against a sample queue and per-packet sums
 */
`default_nettype none

module capture_tb
   import capture_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int DEPTH      = 1 << FIFO_AW;
   localparam int SPARSE_N   = 48;
   localparam int FLOOD_N    = 600;
   // a full FIFO counts DEPTH words, plus output register and holding word
   localparam int FLOOD_KEPT = DEPTH + 2;
   localparam int RUN_CYCLES = 5 + SPARSE_N * 4 + FLOOD_N + FLOOD_KEPT + 13 * 4 + 300;
   localparam int WATCHDOG   = RUN_CYCLES + 2000;

   logic    clk;
   logic    reset;
   logic    i_clear;
   sample_t i_sample;
   logic    i_sample_strobe;
   logic    i_ready;
   sample_t o_data;
   logic    o_last;
   logic    o_valid;
   sum_t    o_sum;
   logic    o_sum_valid;
   level_t  o_dropped;
   level_t  o_space;
   level_t  o_occupied;

   // reference model state
   sample_t exp_q[$];
   sum_t    sum_q[$];
   sample_t exp_word;
   logic    exp_last;
   sum_t    exp_sum;
   sum_t    run_sum;
   int      beat_pos;
   int      xfer_count;
   int      sum_count;

   int data_errs;
   int sum_errs;
   int count_errs;
   int step_errs;
   int tests_passed;
   int tests_failed;
   int seed;

   capture_top capture_top_inst (
      .clk             (clk),
      .reset           (reset),
      .i_clear         (i_clear),
      .i_sample        (i_sample),
      .i_sample_strobe (i_sample_strobe),
      .i_ready         (i_ready),
      .o_data          (o_data),
      .o_last          (o_last),
      .o_valid         (o_valid),
      .o_sum           (o_sum),
      .o_sum_valid     (o_sum_valid),
      .o_dropped       (o_dropped),
      .o_space         (o_space),
      .o_occupied      (o_occupied)
   );

   initial clk = 1'b0;
   always #20 clk = ~clk;

   task automatic report_mismatch(input string sig, input int expected, input int actual);
      $display("ERR %0t %s expected %0h actual %0h", $time, sig, expected, actual);
   endtask

   task automatic check_level(input string sig, input int expected, input int actual);
      assert (actual == expected)
      else
      begin
         report_mismatch(sig, expected, actual);
         step_errs++;
      end
   endtask

   // output monitor, compares every transfer and every packet sum
   always @(posedge clk)
   begin
      if (!reset)
      begin
         assert (32'(o_space) + 32'(o_occupied) == DEPTH)
         else
         begin
            report_mismatch("o_space+o_occupied", DEPTH, 32'(o_space) + 32'(o_occupied));
            count_errs++;
         end
         assert (32'(o_occupied) <= DEPTH)
         else
         begin
            report_mismatch("o_occupied", DEPTH, o_occupied);
            count_errs++;
         end
      end
      if (reset || i_clear)
      begin
         exp_q.delete();
         sum_q.delete();
         run_sum  = '0;
         beat_pos = 0;
      end
      else
      begin
         if (o_valid && i_ready)
         begin
            xfer_count++;
            if (exp_q.size() == 0)
            begin
               $display("word left on o_data at %0t with no sample expected", $time);
               data_errs++;
            end
            else
            begin
               exp_word = exp_q.pop_front();
               exp_last = (beat_pos == PKT_LEN - 1);
               assert (o_data == exp_word)
               else
               begin
                  report_mismatch("o_data", exp_word, o_data);
                  data_errs++;
               end
               assert (o_last == exp_last)
               else
               begin
                  report_mismatch("o_last", exp_last, o_last);
                  data_errs++;
               end
               if (exp_last)
               begin
                  sum_q.push_back(sum_t'(run_sum + exp_word));
                  run_sum  = '0;
                  beat_pos = 0;
               end
               else
               begin
                  run_sum  = sum_t'(run_sum + exp_word);
                  beat_pos = beat_pos + 1;
               end
            end
         end
         if (o_sum_valid)
         begin
            sum_count++;
            if (sum_q.size() == 0)
            begin
               $display("o_sum_valid pulsed at %0t with no packet completed", $time);
               sum_errs++;
            end
            else
            begin
               exp_sum = sum_q.pop_front();
               assert (o_sum == exp_sum)
               else
               begin
                  report_mismatch("o_sum", exp_sum, o_sum);
                  sum_errs++;
               end
            end
         end
      end
   end

   task automatic strobe_sample();
      @(negedge clk);
      i_sample        = sample_t'($random(seed));
      i_sample_strobe = 1'b1;
      exp_q.push_back(i_sample);
   endtask

   // one strobe every fourth cycle
   task automatic send_sparse(input int count);
      for (int i = 0; i < count; i++)
      begin
         strobe_sample();
         @(negedge clk);
         i_sample_strobe = 1'b0;
         repeat (2) @(negedge clk);
      end
   endtask

   // idle means no valid output and an empty FIFO for 8 cycles in a row
   task automatic wait_idle(input int max_cycles);
      int quiet;
      int waited;
      quiet  = 0;
      waited = 0;
      while (quiet < 8 && waited < max_cycles)
      begin
         @(negedge clk);
         waited++;
         if (!o_valid && o_occupied == 0)
            quiet++;
         else
            quiet = 0;
      end
      if (quiet < 8)
      begin
         $display("output did not go idle within %0d cycles", max_cycles);
         step_errs++;
      end
   endtask

   task automatic wait_valid(input int max_cycles);
      int waited;
      waited = 0;
      while (!o_valid && waited < max_cycles)
      begin
         @(negedge clk);
         waited++;
      end
      if (!o_valid)
      begin
         $display("o_valid never rose within %0d cycles", max_cycles);
         step_errs++;
      end
   endtask

   task automatic report_test(input int num, input string name, input int errs);
      if (errs == 0)
      begin
         tests_passed++;
         $display("test %0d %s: ok", num, name);
      end
      else
      begin
         tests_failed++;
         $display("test %0d %s: %0d errors", num, name, errs);
      end
   endtask

   initial
   begin
      int mark_data;
      int mark_sum;
      int mark_step;
      int mark_xfer;
      int mark_sums;
      int assert_fails;

      seed            = 18;
      data_errs       = 0;
      sum_errs        = 0;
      count_errs      = 0;
      step_errs       = 0;
      tests_passed    = 0;
      tests_failed    = 0;
      xfer_count      = 0;
      sum_count       = 0;
      reset           = 1'b1;
      i_clear         = 1'b0;
      i_sample        = '0;
      i_sample_strobe = 1'b0;
      i_ready         = 1'b1;
      repeat (5) @(negedge clk);
      reset = 1'b0;

      // sparse traffic, order then sums
      mark_data = data_errs;
      mark_sum  = sum_errs;
      mark_step = step_errs;
      mark_xfer = xfer_count;
      mark_sums = sum_count;
      send_sparse(SPARSE_N);
      wait_idle(200);
      check_level("words out", SPARSE_N, xfer_count - mark_xfer);
      check_level("samples left", 0, exp_q.size());
      report_test(1, "order", data_errs - mark_data + step_errs - mark_step);
      mark_step = step_errs;
      check_level("packet sums", SPARSE_N / PKT_LEN, sum_count - mark_sums);
      report_test(2, "packet sums", sum_errs - mark_sum + step_errs - mark_step);

      // flood with the output stalled
      mark_data = data_errs;
      mark_sum  = sum_errs;
      mark_step = step_errs;
      mark_xfer = xfer_count;
      i_ready   = 1'b0;
      for (int i = 0; i < FLOOD_N; i++)
         strobe_sample();
      @(negedge clk);
      i_sample_strobe = 1'b0;
      check_level("o_occupied", DEPTH, o_occupied);
      check_level("o_space", 0, o_space);
      i_ready = 1'b1;
      wait_idle(FLOOD_KEPT + 100);
      check_level("drained words", FLOOD_KEPT, xfer_count - mark_xfer);
      check_level("o_dropped", FLOOD_N - FLOOD_KEPT, o_dropped);
      // dropped samples never reach the output
      exp_q.delete();
      assert_fails = capture_top_inst.axi_fifo_bram_inst.capture_assert_inst.fail_count;
      if (assert_fails != 0)
         $display("FIFO assertions failed %0d times during back-pressure", assert_fails);
      report_test(3, "back-pressure",
                  data_errs - mark_data + sum_errs - mark_sum + step_errs - mark_step +
                  assert_fails);

      // clear with words stored, then one fresh packet
      mark_data = data_errs;
      mark_sum  = sum_errs;
      mark_step = step_errs;
      i_ready   = 1'b0;
      send_sparse(5);
      wait_valid(50);
      @(negedge clk);
      i_clear = 1'b1;
      @(negedge clk);
      i_clear = 1'b0;
      check_level("o_valid", 0, o_valid);
      check_level("o_occupied", 0, o_occupied);
      check_level("o_dropped", 0, o_dropped);
      check_level("o_space", DEPTH, o_space);
      mark_sums = sum_count;
      i_ready   = 1'b1;
      send_sparse(PKT_LEN);
      wait_idle(200);
      check_level("packet sums", 1, sum_count - mark_sums);
      check_level("samples left", 0, exp_q.size());
      report_test(5, "clear", data_errs - mark_data + sum_errs - mark_sum + step_errs - mark_step);

      report_test(4, "counters", count_errs);

      assert_fails = capture_top_inst.axi_fifo_bram_inst.capture_assert_inst.fail_count;
      if (assert_fails != 0)
         $display("FIFO assertions failed %0d times in total", assert_fails);
      $display("tests passed %0d failed %0d", tests_passed, tests_failed);
      if (tests_failed == 0 && assert_fails == 0)
         $display("ALL TESTS PASSED");
      else
         $display("SOME TESTS FAILED");
      $finish;
   end

   // watchdog
   initial
   begin
      repeat (WATCHDOG) @(posedge clk);
      $display("timeout, run still going after %0d cycles", WATCHDOG);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* capture.f */
hw/capture_pkg.sv
hw/sample_stream_if.sv
hw/ram_2port.sv
hw/sample_packetizer.sv
hw/axi_fifo_bram.sv
hw/packet_checksum.sv
hw/capture_top.sv
sim/capture_assert.sv
sim/capture_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the capture testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --assert --timescale 1ns/100ps -Wno-fatal \
   --top-module capture_tb -Mdir "$OBJ" -f capture.f
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

# keep running past assertion errors so the testbench reports them
"./$OBJ/Vcapture_tb" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^ALL TESTS PASSED$" "$LOG"; then
   exit 0
fi
echo "pass message not found in $LOG"
exit 1
